/* files.f */
logic/linemult_pkg.sv
logic/line_writer.sv
logic/line_buffer.sv
logic/line_reader.sv
logic/scanline_shader.sv
logic/linemult_top.sv
test/tb_clock_gen.sv
test/linemult_tb.sv

/* Makefile */
# Verilator build and run for the line doubler testbench

VERILATOR ?= verilator
TOP       ?= linemult_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

/* test/linemult_tb.sv */
/*
 * linemult_tb
 * drives bypass, doubled frames with scanlines and an overflowed line
 * into the line doubler and checks pixels and regenerated syncs
 * against a reference model
 */

`timescale 1ns/1ns

module linemult_tb;

  localparam int LINE_PIX        = 780;
  localparam int LONG_PIX        = 1000;
  localparam int HS_PIX          = 20;
  localparam int LINES_PER_FRAME = 6;
  localparam int VS_LINES        = 3;
  localparam int WIN_START       = int'(linemult_pkg::H_ACTIVE_START);
  localparam int WIN_STOP        = int'(linemult_pkg::H_ACTIVE_STOP);
  // lines read twice: frames of 6, 6, 2, 6 and 2
  localparam int EXPECTED_RUNS   = 2 * 22;
  // 25 normal lines plus one long line, two clocks per pixel, plus margin
  localparam int TIMEOUT_CYCLES  = 2 * (25 * LINE_PIX + LONG_PIX) + 4 * 2 * LINE_PIX;

  logic        VCLK_Tx;
  logic        nVRST_Tx;
  logic        enable_i;
  logic        pix_en_i;
  logic        nhsync_i;
  logic        nvsync_i;
  logic [6:0]  red_i;
  logic [6:0]  green_i;
  logic [6:0]  blue_i;
  logic        sl_en_i;
  logic        sl_id_i;
  logic [3:0]  sl_str_i;
  logic        pix_en_o;
  logic        de_o;
  logic        nhsync_o;
  logic        nvsync_o;
  logic [7:0]  red_o;
  logic [7:0]  green_o;
  logic [7:0]  blue_o;

  // stimulus bookkeeping
  logic [31:0] rng_state;
  logic [20:0] cur_line[$];
  logic [20:0] prev_line[$];
  logic [20:0] expect_q[$];
  bit          cur_valid;
  bit          prev_valid;
  bit          no_de_expected;
  int          skip_intervals;
  int          cycle_cnt;

  // input snapshot from the previous falling edge
  bit          snap_valid;
  logic        s_en;
  logic        s_pix;
  logic        s_nhs;
  logic        s_nvs;
  logic [6:0]  s_red;
  logic [6:0]  s_green;
  logic [6:0]  s_blue;

  // output tracking
  bit          in_run;
  int          run_len;
  int          copy_idx;
  int          runs_this_line;
  int          runs_total;
  int          frame_runs;
  int          frame_hs;
  int          vs_hs;
  int          hs_len;
  logic        nhs_last;
  logic        nvs_last;
  logic [20:0] px;
  logic        dim;

  tb_clock_gen clock_gen_i (
    .clk_o   (VCLK_Tx),
    .rst_n_o (nVRST_Tx)
  );

  linemult_top linemult_top_i (
    .VCLK_Tx  (VCLK_Tx),
    .nVRST_Tx (nVRST_Tx),
    .enable_i (enable_i),
    .pix_en_i (pix_en_i),
    .nhsync_i (nhsync_i),
    .nvsync_i (nvsync_i),
    .red_i    (red_i),
    .green_i  (green_i),
    .blue_i   (blue_i),
    .sl_en_i  (sl_en_i),
    .sl_id_i  (sl_id_i),
    .sl_str_i (sl_str_i),
    .pix_en_o (pix_en_o),
    .de_o     (de_o),
    .nhsync_o (nhsync_o),
    .nvsync_o (nvsync_o),
    .red_o    (red_o),
    .green_o  (green_o),
    .blue_o   (blue_o)
  );

  ////////////////////////////////
  // helpers
  ////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 7 bit color widened by its msb, scaled by (15 - str) / 16 when dimmed
  function automatic logic [7:0] expected_color(
    input logic [6:0] c,
    input logic [3:0] str,
    input logic       dim_en
  );
    logic [7:0]  full;
    logic [11:0] prod;
    full = {c, c[6]};
    prod = {4'd0, full} * (12'd15 - {8'd0, str});
    if (dim_en) begin
      return prod[11:4];
    end
    return full;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("Mismatch %s expected %0h actual %0h", name, exp, act);
      fail_run("value check failed");
    end
  endtask

  // one input line, one pixel every second clock
  task automatic drive_line(
    input int       npix,
    input bit       vs_low,
    input bit       long_line,
    input bit       sl_en,
    input bit       sl_id,
    input bit [3:0] sl_str
  );
    int i;
    for (i = 0; i < npix; i++) begin
      @(posedge VCLK_Tx);
      #2;
      if (i == 0) begin
        if (enable_i && runs_this_line == 1) begin
          fail_run("input line was read out only once");
        end
        prev_line      = cur_line;
        // only a line stored in doubling mode may be read out
        prev_valid     = cur_valid;
        cur_valid      = enable_i;
        cur_line.delete();
        runs_this_line = 0;
        no_de_expected = 1'b0;
        sl_en_i        = sl_en;
        sl_id_i        = sl_id;
        sl_str_i       = sl_str;
      end
      // past here the line has no hsync edge the reader could follow
      if (long_line && i == LINE_PIX) begin
        no_de_expected = 1'b1;
        skip_intervals = 2;
      end
      rng_state = xorshift(rng_state);
      pix_en_i  = 1'b1;
      nhsync_i  = (i >= HS_PIX);
      nvsync_i  = !vs_low;
      red_i     = rng_state[6:0];
      green_i   = rng_state[13:7];
      blue_i    = rng_state[20:14];
      if (i >= WIN_START && i < WIN_STOP) begin
        cur_line.push_back({red_i, green_i, blue_i});
      end
      @(posedge VCLK_Tx);
      #2;
      pix_en_i = 1'b0;
    end
  endtask

  ////////////////////////////////
  // stimulus
  ////////////////////////////////

  initial begin
    int j;
    bit [3:0] str_tab [3];
    str_tab[0] = 4'd0;
    str_tab[1] = 4'd7;
    str_tab[2] = 4'd15;
    enable_i       = 1'b0;
    pix_en_i       = 1'b0;
    nhsync_i       = 1'b1;
    nvsync_i       = 1'b1;
    red_i          = '0;
    green_i        = '0;
    blue_i         = '0;
    sl_en_i        = 1'b0;
    sl_id_i        = 1'b0;
    sl_str_i       = '0;
    rng_state      = 32'h3256;
    cur_valid      = 1'b0;
    prev_valid     = 1'b0;
    no_de_expected = 1'b0;
    skip_intervals = 2;
    runs_this_line = 0;

    // outputs during reset
    @(negedge VCLK_Tx);
    check_value("reset de_o", 0, de_o);
    check_value("reset pix_en_o", 0, pix_en_o);
    check_value("reset nhsync_o", 1, nhsync_o);
    check_value("reset nvsync_o", 1, nvsync_o);
    check_value("reset red_o", 0, red_o);
    check_value("reset green_o", 0, green_o);
    check_value("reset blue_o", 0, blue_o);
    wait (nVRST_Tx);

    // bypass
    for (j = 0; j < 2; j++) begin
      drive_line(LINE_PIX, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0);
    end
    @(posedge VCLK_Tx);
    #2;
    enable_i = 1'b1;

    // plain doubling
    for (j = 0; j < LINES_PER_FRAME; j++) begin
      drive_line(LINE_PIX, j < VS_LINES, 1'b0, 1'b0, 1'b0, 4'd0);
    end
    // scanlines on both copies with all three strengths
    for (j = 0; j < LINES_PER_FRAME; j++) begin
      drive_line(LINE_PIX, j < VS_LINES, 1'b0, 1'b1, j[0], str_tab[j % 3]);
    end
    // two lines then one without an hsync edge in time
    drive_line(LINE_PIX, 1'b1, 1'b0, 1'b1, 1'b0, 4'd15);
    drive_line(LINE_PIX, 1'b1, 1'b0, 1'b1, 1'b0, 4'd15);
    drive_line(LONG_PIX, 1'b0, 1'b1, 1'b1, 1'b0, 4'd15);
    // doubling resumes after the next frame start
    for (j = 0; j < LINES_PER_FRAME; j++) begin
      drive_line(LINE_PIX, j < VS_LINES, 1'b0, 1'b1, 1'b1, 4'd7);
    end
    for (j = 0; j < 3; j++) begin
      drive_line(LINE_PIX, j < VS_LINES, 1'b0, 1'b0, 1'b0, 4'd0);
    end

    repeat (40) @(posedge VCLK_Tx);
    if (runs_total == EXPECTED_RUNS) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      check_value("doubled output runs", EXPECTED_RUNS, runs_total);
    end
  end

  ////////////////////////////////
  // output checking
  ////////////////////////////////

  // sampled on the falling edge, half a clock away from any change
  always @(negedge VCLK_Tx) begin
    if (nVRST_Tx && snap_valid) begin
      if (!s_en) begin
        check_value("bypass de_o", s_pix, de_o);
        check_value("bypass pix_en_o", s_pix, pix_en_o);
        check_value("bypass nhsync_o", s_nhs, nhsync_o);
        check_value("bypass nvsync_o", s_nvs, nvsync_o);
        check_value("bypass red_o", expected_color(s_red, 4'd0, 1'b0), red_o);
        check_value("bypass green_o", expected_color(s_green, 4'd0, 1'b0), green_o);
        check_value("bypass blue_o", expected_color(s_blue, 4'd0, 1'b0), blue_o);
        in_run   = 1'b0;
        hs_len   = 0;
        nhs_last = 1'b1;
        nvs_last = 1'b1;
      end else begin
        check_value("doubling pix_en_o", 1, pix_en_o);
        if (no_de_expected && de_o) begin
          fail_run("de_o went high while the line was overflowed");
        end

        // frame interval ends at each vsync fall
        if (nvs_last && !nvsync_o) begin
          // vsync starts together with an output line
          if (!(nhs_last && !nhsync_o)) begin
            fail_run("nvsync_o fell away from the start of an output line");
          end
          if (skip_intervals == 0) begin
            check_value("hsync pulses per frame", 2 * LINES_PER_FRAME, frame_hs);
            check_value("runs per frame", frame_hs, frame_runs);
          end else begin
            skip_intervals--;
          end
          frame_hs   = 0;
          frame_runs = 0;
          vs_hs      = 0;
        end
        if (nhs_last && !nhsync_o) begin
          frame_hs++;
          if (!nvsync_o) begin
            vs_hs++;
          end
        end
        if (!nvs_last && nvsync_o) begin
          check_value("vsync output lines", int'(linemult_pkg::VS_WIDTH), vs_hs);
        end

        // hsync pulse width
        if (!nhsync_o) begin
          hs_len++;
        end else if (!nhs_last) begin
          check_value("hsync width", int'(linemult_pkg::HS_WIDTH), hs_len);
          hs_len = 0;
        end

        if (de_o) begin
          if (!in_run) begin
            if (!prev_valid) begin
              fail_run("de_o active before any input line was complete");
            end
            if (runs_this_line >= 2) begin
              fail_run("input line was read out more than twice");
            end
            in_run   = 1'b1;
            run_len  = 0;
            copy_idx = runs_this_line;
            runs_this_line++;
            runs_total++;
            frame_runs++;
            expect_q = prev_line;
          end
          if (expect_q.size() == 0) begin
            fail_run("output run is longer than the active window");
          end
          px  = expect_q.pop_front();
          dim = sl_en_i && (copy_idx == int'(sl_id_i));
          check_value("pixel red", expected_color(px[20:14], sl_str_i, dim), red_o);
          check_value("pixel green", expected_color(px[13:7], sl_str_i, dim), green_o);
          check_value("pixel blue", expected_color(px[6:0], sl_str_i, dim), blue_o);
          run_len++;
        end else begin
          if (in_run) begin
            check_value("run length", linemult_pkg::H_ACTIVE_LEN, run_len);
            in_run = 1'b0;
          end
          check_value("blank red", 0, red_o);
          check_value("blank green", 0, green_o);
          check_value("blank blue", 0, blue_o);
        end
        nhs_last = nhsync_o;
        nvs_last = nvsync_o;
      end
    end
    snap_valid = nVRST_Tx;
    s_en       = enable_i;
    s_pix      = pix_en_i;
    s_nhs      = nhsync_i;
    s_nvs      = nvsync_i;
    s_red      = red_i;
    s_green    = green_i;
    s_blue     = blue_i;
  end

  initial begin
    snap_valid = 1'b0;
    in_run     = 1'b0;
    runs_total = 0;
    frame_runs = 0;
    frame_hs   = 0;
    vs_hs      = 0;
    hs_len     = 0;
    nhs_last   = 1'b1;
    nvs_last   = 1'b1;
    cycle_cnt  = 0;
  end

  // run limit
  always @(posedge VCLK_Tx) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_run("simulation did not finish within the cycle limit");
    end
  end

endmodule

/* test/tb_clock_gen.sv */
/*
 * tb_clock_gen
 * free running testbench clock and active low power on reset
 */

`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD = 10;
  localparam int RST_CYCLES  = 10;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // release a little after the edge so no flop sees it change at the edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

/* logic/linemult_top.sv */
/*
 * linemult_top
 * line doubler for digital N64 video: writer, two page buffer,
 * double rate reader and scanline output stage
 */

`timescale 1ns/1ns

module linemult_top (
  input  logic                                VCLK_Tx,
  input  logic                                nVRST_Tx,
  input  logic                                enable_i,
  input  logic                                pix_en_i,
  input  logic                                nhsync_i,
  input  logic                                nvsync_i,
  input  logic [linemult_pkg::COLOR_W-1:0]    red_i,
  input  logic [linemult_pkg::COLOR_W-1:0]    green_i,
  input  logic [linemult_pkg::COLOR_W-1:0]    blue_i,
  input  logic                                sl_en_i,
  input  logic                                sl_id_i,
  input  logic [linemult_pkg::SL_STR_W-1:0]   sl_str_i,
  output logic                                pix_en_o,
  output logic                                de_o,
  output logic                                nhsync_o,
  output logic                                nvsync_o,
  output logic [linemult_pkg::COLOR_O_W-1:0]  red_o,
  output logic [linemult_pkg::COLOR_O_W-1:0]  green_o,
  output logic [linemult_pkg::COLOR_O_W-1:0]  blue_o
);

  // write side
  logic                              wr_en;
  logic [linemult_pkg::PAGE_W-1:0]   wr_page;
  logic [linemult_pkg::HCNT_W-1:0]   wr_addr;
  linemult_pkg::rgb_t                wr_data;
  logic                              line_start;
  logic                              frame_start;
  logic [linemult_pkg::HCNT_W-1:0]   line_width;
  logic                              overflow;

  // read side
  logic                              rd_en;
  logic [linemult_pkg::PAGE_W-1:0]   rd_page;
  logic [linemult_pkg::HCNT_W-1:0]   rd_addr;
  linemult_pkg::rgb_t                rd_data;
  logic                              rd_de;
  logic                              rd_copy;
  logic                              rd_nhsync;
  logic                              rd_nvsync;

  line_writer line_writer_i (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .pix_en_i      (pix_en_i),
    .nhsync_i      (nhsync_i),
    .nvsync_i      (nvsync_i),
    .red_i         (red_i),
    .green_i       (green_i),
    .blue_i        (blue_i),
    .wr_en_o       (wr_en),
    .wr_page_o     (wr_page),
    .wr_addr_o     (wr_addr),
    .wr_data_o     (wr_data),
    .line_start_o  (line_start),
    .frame_start_o (frame_start),
    .line_width_o  (line_width),
    .overflow_o    (overflow)
  );

  line_buffer line_buffer_i (
    .VCLK_Tx   (VCLK_Tx),
    .wr_en_i   (wr_en),
    .wr_page_i (wr_page),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_en_i   (rd_en),
    .rd_page_i (rd_page),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  line_reader line_reader_i (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .enable_i      (enable_i),
    .line_start_i  (line_start),
    .frame_start_i (frame_start),
    .line_width_i  (line_width),
    .wr_page_i     (wr_page),
    .overflow_i    (overflow),
    .rd_en_o       (rd_en),
    .rd_page_o     (rd_page),
    .rd_addr_o     (rd_addr),
    .rd_de_o       (rd_de),
    .rd_copy_o     (rd_copy),
    .rd_nhsync_o   (rd_nhsync),
    .rd_nvsync_o   (rd_nvsync)
  );

  scanline_shader scanline_shader_i (
    .VCLK_Tx     (VCLK_Tx),
    .nVRST_Tx    (nVRST_Tx),
    .enable_i    (enable_i),
    .sl_en_i     (sl_en_i),
    .sl_id_i     (sl_id_i),
    .sl_str_i    (sl_str_i),
    .rd_de_i     (rd_de),
    .rd_copy_i   (rd_copy),
    .rd_nhsync_i (rd_nhsync),
    .rd_nvsync_i (rd_nvsync),
    .rd_data_i   (rd_data),
    .pix_en_i    (pix_en_i),
    .nhsync_i    (nhsync_i),
    .nvsync_i    (nvsync_i),
    .red_i       (red_i),
    .green_i     (green_i),
    .blue_i      (blue_i),
    .de_o        (de_o),
    .pix_en_o    (pix_en_o),
    .nhsync_o    (nhsync_o),
    .nvsync_o    (nvsync_o),
    .red_o       (red_o),
    .green_o     (green_o),
    .blue_o      (blue_o)
  );

endmodule

/* logic/scanline_shader.sv */
/*
 * scanline_shader
 * lines the reader syncs up with buffer data, darkens the selected
 * copy as a scanline and falls back to the raw input in bypass
 */

`timescale 1ns/1ns

module scanline_shader (
  input  logic                                VCLK_Tx,
  input  logic                                nVRST_Tx,
  input  logic                                enable_i,
  input  logic                                sl_en_i,
  input  logic                                sl_id_i,
  input  logic [linemult_pkg::SL_STR_W-1:0]   sl_str_i,
  input  logic                                rd_de_i,
  input  logic                                rd_copy_i,
  input  logic                                rd_nhsync_i,
  input  logic                                rd_nvsync_i,
  input  linemult_pkg::rgb_t                  rd_data_i,
  input  logic                                pix_en_i,
  input  logic                                nhsync_i,
  input  logic                                nvsync_i,
  input  logic [linemult_pkg::COLOR_W-1:0]    red_i,
  input  logic [linemult_pkg::COLOR_W-1:0]    green_i,
  input  logic [linemult_pkg::COLOR_W-1:0]    blue_i,
  output logic                                de_o,
  output logic                                pix_en_o,
  output logic                                nhsync_o,
  output logic                                nvsync_o,
  output logic [linemult_pkg::COLOR_O_W-1:0]  red_o,
  output logic [linemult_pkg::COLOR_O_W-1:0]  green_o,
  output logic [linemult_pkg::COLOR_O_W-1:0]  blue_o
);

  logic de_q;
  logic copy_q;
  logic nhs_q;
  logic nvs_q;
  logic dim;

  // 7 to 8 bit by repeating the msb
  function automatic logic [linemult_pkg::COLOR_O_W-1:0] extend(
    input logic [linemult_pkg::COLOR_W-1:0] c
  );
    return {c, c[linemult_pkg::COLOR_W-1]};
  endfunction

  // scale by (15 - str) / 16 when dimming
  function automatic logic [linemult_pkg::COLOR_O_W-1:0] shade(
    input logic [linemult_pkg::COLOR_W-1:0]  c,
    input logic                              dim_en,
    input logic [linemult_pkg::SL_STR_W-1:0] str
  );
    logic [linemult_pkg::COLOR_O_W+linemult_pkg::SL_STR_W-1:0] prod;
    prod = extend(c) * ({linemult_pkg::SL_STR_W{1'b1}} - str);
    if (dim_en) begin
      return prod[linemult_pkg::COLOR_O_W+linemult_pkg::SL_STR_W-1:linemult_pkg::SL_STR_W];
    end
    return extend(c);
  endfunction

  assign dim = sl_en_i && (copy_q == sl_id_i);

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      de_q     <= 1'b0;
      copy_q   <= 1'b0;
      nhs_q    <= 1'b1;
      nvs_q    <= 1'b1;
      de_o     <= 1'b0;
      pix_en_o <= 1'b0;
      nhsync_o <= 1'b1;
      nvsync_o <= 1'b1;
      red_o    <= '0;
      green_o  <= '0;
      blue_o   <= '0;
    end else begin
      // stage 1 waits for the buffer read
      de_q   <= rd_de_i;
      copy_q <= rd_copy_i;
      nhs_q  <= rd_nhsync_i;
      nvs_q  <= rd_nvsync_i;

      if (!enable_i) begin
        de_o     <= pix_en_i;
        pix_en_o <= pix_en_i;
        nhsync_o <= nhsync_i;
        nvsync_o <= nvsync_i;
        red_o    <= extend(red_i);
        green_o  <= extend(green_i);
        blue_o   <= extend(blue_i);
      end else begin
        de_o     <= de_q;
        pix_en_o <= 1'b1;
        nhsync_o <= nhs_q;
        nvsync_o <= nvs_q;
        if (de_q) begin
          red_o   <= shade(rd_data_i.red, dim, sl_str_i);
          green_o <= shade(rd_data_i.green, dim, sl_str_i);
          blue_o  <= shade(rd_data_i.blue, dim, sl_str_i);
        end else begin
          // black in blanking
          red_o   <= '0;
          green_o <= '0;
          blue_o  <= '0;
        end
      end
    end
  end

endmodule

/* logic/line_reader.sv */
/*
 * line_reader
 * reads each completed input line twice at full clock rate and
 * regenerates hsync, vsync and data enable at the doubled line rate
 */

`timescale 1ns/1ns

module line_reader (
  input  logic                              VCLK_Tx,
  input  logic                              nVRST_Tx,
  input  logic                              enable_i,
  input  logic                              line_start_i,
  input  logic                              frame_start_i,
  input  logic [linemult_pkg::HCNT_W-1:0]   line_width_i,
  input  logic [linemult_pkg::PAGE_W-1:0]   wr_page_i,
  input  logic                              overflow_i,
  output logic                              rd_en_o,
  output logic [linemult_pkg::PAGE_W-1:0]   rd_page_o,
  output logic [linemult_pkg::HCNT_W-1:0]   rd_addr_o,
  output logic                              rd_de_o,
  output logic                              rd_copy_o,
  output logic                              rd_nhsync_o,
  output logic                              rd_nvsync_o
);

  linemult_pkg::rd_state_e           state;
  logic [linemult_pkg::HCNT_W-1:0]   hcnt;
  logic [linemult_pkg::HCNT_W-1:0]   width;
  logic                              copy;
  logic [linemult_pkg::VCNT_W-1:0]   vcnt;
  logic                              vs_pend;
  logic                              run;
  logic                              line_last;
  logic                              ln_begin;

  assign run       = (state == linemult_pkg::RD_RUN);
  assign line_last = run && (hcnt == width - 1'b1);

  // a new output line starts on an accepted line start or after copy 0
  assign ln_begin = (line_start_i && (state != linemult_pkg::RD_IDLE)) ||
                    (line_last && !copy);

  //////////////////////////////
  // state machine and h counter
  //////////////////////////////

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      state     <= linemult_pkg::RD_IDLE;
      hcnt      <= '0;
      width     <= '0;
      copy      <= 1'b0;
      rd_page_o <= '0;
    end else if (!enable_i || overflow_i) begin
      state <= linemult_pkg::RD_IDLE;
      hcnt  <= '0;
      copy  <= 1'b0;
    end else if (line_start_i && (state != linemult_pkg::RD_IDLE)) begin
      // writer has just flipped pages, read the one it left
      state     <= linemult_pkg::RD_RUN;
      hcnt      <= '0;
      copy      <= 1'b0;
      width     <= line_width_i;
      rd_page_o <= ~wr_page_i;
    end else begin
      case (state)
        linemult_pkg::RD_IDLE: begin
          if (frame_start_i) begin
            state <= linemult_pkg::RD_ARMED;
          end
        end
        linemult_pkg::RD_RUN: begin
          if (line_last) begin
            hcnt <= '0;
            copy <= ~copy;
            // both copies out, wait for the next input line
            if (copy) begin
              state <= linemult_pkg::RD_ARMED;
            end
          end else begin
            hcnt <= hcnt + 1'b1;
          end
        end
        default: begin
          state <= state;
        end
      endcase
    end
  end

  //////////////////////////////
  // vertical line counter
  //////////////////////////////

  // cleared on the first output line that starts at or after a frame start
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vcnt    <= linemult_pkg::VS_WIDTH;
      vs_pend <= 1'b0;
    end else if (ln_begin) begin
      vs_pend <= 1'b0;
      if (frame_start_i || vs_pend) begin
        vcnt <= '0;
      end else if (vcnt != linemult_pkg::VS_WIDTH) begin
        vcnt <= vcnt + 1'b1;
      end
    end else if (frame_start_i) begin
      // vsync stays off until the first output line of the new frame
      vs_pend <= 1'b1;
      vcnt    <= linemult_pkg::VS_WIDTH;
    end
  end

  // outputs
  assign rd_de_o     = run && (hcnt >= linemult_pkg::H_ACTIVE_START) &&
                       (hcnt < linemult_pkg::H_ACTIVE_STOP);
  assign rd_en_o     = rd_de_o;
  assign rd_addr_o   = hcnt - linemult_pkg::H_ACTIVE_START;
  assign rd_copy_o   = copy;
  assign rd_nhsync_o = ~(run && (hcnt < linemult_pkg::HS_WIDTH));
  assign rd_nvsync_o = ~((state != linemult_pkg::RD_IDLE) && (vcnt < linemult_pkg::VS_WIDTH));

  // the page being read is never the one being filled
  a_page_separation: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (run && !line_start_i) |-> (rd_page_o != wr_page_i)
  );

endmodule

/* logic/line_buffer.sv */
/*
 * line_buffer
 * two page pixel memory, one window line per page,
 * independent write and registered read port
 */

`timescale 1ns/1ns

module line_buffer (
  input  logic                              VCLK_Tx,
  input  logic                              wr_en_i,
  input  logic [linemult_pkg::PAGE_W-1:0]   wr_page_i,
  input  logic [linemult_pkg::HCNT_W-1:0]   wr_addr_i,
  input  linemult_pkg::rgb_t                wr_data_i,
  input  logic                              rd_en_i,
  input  logic [linemult_pkg::PAGE_W-1:0]   rd_page_i,
  input  logic [linemult_pkg::HCNT_W-1:0]   rd_addr_i,
  output linemult_pkg::rgb_t                rd_data_o
);

  linemult_pkg::rgb_t mem [linemult_pkg::BUF_PAGES][linemult_pkg::H_ACTIVE_LEN];

  always_ff @(posedge VCLK_Tx) begin
    if (wr_en_i) begin
      mem[wr_page_i][wr_addr_i] <= wr_data_i;
    end
  end

  // one clock read latency
  always_ff @(posedge VCLK_Tx) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_page_i][rd_addr_i];
    end
  end

  // writer and reader must never meet on one location
  a_no_rw_collision: assert property (
    @(posedge VCLK_Tx)
    !(wr_en_i && rd_en_i && (wr_page_i == rd_page_i) && (wr_addr_i == rd_addr_i))
  );

endmodule

/* logic/line_writer.sv */
/*
 * line_writer
 * finds hsync and vsync falling edges in the enabled input stream,
 * counts pixels per line and writes the active window of each line
 * into the current page of the line buffer
 */

`timescale 1ns/1ns

module line_writer (
  input  logic                                 VCLK_Tx,
  input  logic                                 nVRST_Tx,
  input  logic                                 pix_en_i,
  input  logic                                 nhsync_i,
  input  logic                                 nvsync_i,
  input  logic [linemult_pkg::COLOR_W-1:0]     red_i,
  input  logic [linemult_pkg::COLOR_W-1:0]     green_i,
  input  logic [linemult_pkg::COLOR_W-1:0]     blue_i,
  output logic                                 wr_en_o,
  output logic [linemult_pkg::PAGE_W-1:0]      wr_page_o,
  output logic [linemult_pkg::HCNT_W-1:0]      wr_addr_o,
  output linemult_pkg::rgb_t                   wr_data_o,
  output logic                                 line_start_o,
  output logic                                 frame_start_o,
  output logic [linemult_pkg::HCNT_W-1:0]      line_width_o,
  output logic                                 overflow_o
);

  logic                              nhs_q;
  logic                              nvs_q;
  logic                              hs_fall;
  logic                              vs_fall;
  logic [linemult_pkg::HCNT_W-1:0]   pix_cnt;
  logic [linemult_pkg::HCNT_W-1:0]   pix_pos;
  logic                              in_window;

  assign hs_fall = pix_en_i & nhs_q & ~nhsync_i;
  assign vs_fall = pix_en_i & nvs_q & ~nvsync_i;

  // the pixel carrying the hsync edge is position 0 of the new line
  assign pix_pos   = hs_fall ? '0 : pix_cnt;
  assign in_window = (pix_pos >= linemult_pkg::H_ACTIVE_START) &&
                     (pix_pos < linemult_pkg::H_ACTIVE_STOP);

  // count is being cleared on an edge cycle, so no overflow there
  assign overflow_o = (pix_cnt == linemult_pkg::LINE_PIX_MAX) & ~hs_fall;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      nhs_q         <= 1'b1;
      nvs_q         <= 1'b1;
      pix_cnt       <= '0;
      line_width_o  <= '0;
      wr_page_o     <= '0;
      wr_en_o       <= 1'b0;
      line_start_o  <= 1'b0;
      frame_start_o <= 1'b0;
    end else begin
      line_start_o  <= hs_fall;
      frame_start_o <= vs_fall;
      wr_en_o       <= pix_en_i & in_window;
      if (pix_en_i) begin
        nhs_q <= nhsync_i;
        nvs_q <= nvsync_i;
        if (hs_fall) begin
          line_width_o <= pix_cnt;
          pix_cnt      <= {{(linemult_pkg::HCNT_W-1){1'b0}}, 1'b1};
          wr_page_o    <= ~wr_page_o;
        end else if (pix_cnt != linemult_pkg::LINE_PIX_MAX) begin
          pix_cnt <= pix_cnt + 1'b1;
        end
      end
    end
  end

  // window pixels go to consecutive addresses
  always_ff @(posedge VCLK_Tx) begin
    if (pix_en_i && in_window) begin
      wr_addr_o <= pix_pos - linemult_pkg::H_ACTIVE_START;
      wr_data_o <= {red_i, green_i, blue_i};
    end
  end

  // the source delivers at most one pixel every second clock
  a_pix_en_rate: assert property (
    @(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    pix_en_i |=> !pix_en_i
  );

endmodule

/* logic/linemult_pkg.sv */
/*
 * linemult_pkg
 * shared geometry, widths, pixel word and reader state encoding
 * for the single clock N64 line doubler
 */

package linemult_pkg;

  ////////////////////////////////
  // widths
  ////////////////////////////////

  localparam int COLOR_W   = 7;
  localparam int COLOR_O_W = 8;
  localparam int HCNT_W    = 10;
  localparam int PAGE_W    = 1;
  localparam int BUF_PAGES = 2;
  localparam int SL_STR_W  = 4;
  // vertical counter only has to reach VS_WIDTH, it saturates there
  localparam int VCNT_W    = 3;

  ////////////////////////////////
  // NTSC line geometry
  ////////////////////////////////

  // input pixels after hsync fall
  localparam logic [HCNT_W-1:0] LINE_PIX_MAX   = 10'd800;
  localparam logic [HCNT_W-1:0] H_ACTIVE_START = 10'd128;
  localparam logic [HCNT_W-1:0] H_ACTIVE_STOP  = 10'd768;
  localparam int                H_ACTIVE_LEN   = int'(H_ACTIVE_STOP - H_ACTIVE_START);

  // output sync shapes
  localparam logic [HCNT_W-1:0] HS_WIDTH = 10'd32;
  localparam logic [VCNT_W-1:0] VS_WIDTH = 3'd6;

  ////////////////////////////////
  // types
  ////////////////////////////////

  typedef struct packed {
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;
  } rgb_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ARMED,
    RD_RUN
  } rd_state_e;

endpackage
